// File: ipv4_csum.sv
`include "roce_pkt_defs.svh"

module ipv4_csum
  import roce_hdr_pkg::*;
(
  input  logic [15:0] total_len_i,
  input  ipv4_addr_t  src_ip_i,
  input  ipv4_addr_t  dst_ip_i,
  output logic [15:0] csum_o
);

  logic [19:0] sum;
  logic [16:0] fold1;
  logic [15:0] fold2;

  // ten header words, checksum word taken as zero
  assign sum = 20'({`ROCE_IP_VER_IHL, `ROCE_IP_TOS})
             + 20'(total_len_i)
             + 20'(`ROCE_IP_ID)
             + 20'(`ROCE_IP_FLAGS)
             + 20'({`ROCE_IP_TTL, `ROCE_IP_PROTO_UDP})
             + 20'(src_ip_i[31:16])
             + 20'(src_ip_i[15:0])
             + 20'(dst_ip_i[31:16])
             + 20'(dst_ip_i[15:0]);

  // second fold catches the carry out of the first
  assign fold1  = 17'(sum[15:0]) + 17'(sum[19:16]);
  assign fold2  = fold1[15:0] + 16'(fold1[16]);
  assign csum_o = ~fold2;

endmodule

// File: qp_addr_table.sv
`include "roce_pkt_defs.svh"

module qp_addr_table
  import roce_hdr_pkg::*;
(
  input  logic                               core_clk,
  input  logic                               core_aresetn,
  input  logic                               qp_wr_i,
  input  logic [$clog2(`ROCE_QP_ENTRIES)-1:0] qp_wr_idx_i,
  input  mac_addr_t                          qp_wr_mac_i,
  input  ipv4_addr_t                         qp_wr_ip_i,
  input  logic [$clog2(`ROCE_QP_ENTRIES)-1:0] rd_idx_i,
  output mac_addr_t                          rd_mac_o,
  output ipv4_addr_t                         rd_ip_o
);

  mac_addr_t  mac_q [`ROCE_QP_ENTRIES];
  ipv4_addr_t ip_q  [`ROCE_QP_ENTRIES];

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      for (int i = 0; i < `ROCE_QP_ENTRIES; i++) begin
        mac_q[i] <= '0;
        ip_q[i]  <= '0;
      end
    end else if (qp_wr_i) begin
      mac_q[qp_wr_idx_i] <= qp_wr_mac_i;
      ip_q[qp_wr_idx_i]  <= qp_wr_ip_i;
    end
  end

  // async read
  assign rd_mac_o = mac_q[rd_idx_i];
  assign rd_ip_o  = ip_q[rd_idx_i];

endmodule

// File: roce_hdr_builder.sv
`include "roce_pkt_defs.svh"

module roce_hdr_builder
  import roce_hdr_pkg::*;
  import roce_tx_pkg::*;
(
  input  logic        core_clk,
  input  logic        core_aresetn,
  input  logic        cap_i,
  input  req_kind_e   kind_i,
  input  qp_num_t     qp_i,
  input  psn_t        psn_i,
  input  mac_addr_t   src_mac_i,
  input  ipv4_addr_t  src_ip_i,
  input  mac_addr_t   dst_mac_i,
  input  ipv4_addr_t  dst_ip_i,
  input  logic [15:0] csum_i,
  output logic [15:0] total_len_o,
  output logic [((`ROCE_RD_RESP_BYTES*8+`ROCE_DATA_W-1)/`ROCE_DATA_W)*`ROCE_DATA_W-1:0] pkt_o
);

  localparam int PKT_W =
    ((`ROCE_RD_RESP_BYTES*8 + `ROCE_DATA_W - 1) / `ROCE_DATA_W) * `ROCE_DATA_W;

  bth_opcode_e      opcode;
  logic [15:0]      total_len;
  logic [15:0]      udp_len;
  hdr_bytes_t       hdr;
  logic [PKT_W-1:0] pkt_d;
  logic [PKT_W-1:0] pkt_q;

  assign opcode    = (kind_i == REQ_RD_RESP) ? OP_RD_RESP_ONLY : OP_ACK;
  assign total_len = (kind_i == REQ_RD_RESP) ? `ROCE_IP_LEN_RD_RESP : `ROCE_IP_LEN_ACK;
  // udp length excludes the 20-byte ip header
  assign udp_len   = total_len - 16'd20;

  assign hdr = {
    dst_mac_i, src_mac_i, `ROCE_ETHERTYPE,
    `ROCE_IP_VER_IHL, `ROCE_IP_TOS, total_len, `ROCE_IP_ID, `ROCE_IP_FLAGS,
    `ROCE_IP_TTL, `ROCE_IP_PROTO_UDP, csum_i, src_ip_i, dst_ip_i,
    `ROCE_UDP_SPORT, `ROCE_UDP_DPORT, udp_len, 16'h0000,
    opcode, 8'h00, `ROCE_BTH_PKEY, 8'h00, qp_i, 8'h00, psn_i,
    32'h0000_0000
  };

  always_comb begin
    pkt_d = '0;
    // packet byte 0 goes to bits 7:0
    for (int i = 0; i < `ROCE_HDR_BYTES; i++) begin
      pkt_d[i*8 +: 8] = hdr[(`ROCE_HDR_BYTES-1-i)*8 +: 8];
    end
    if (kind_i == REQ_RD_RESP) begin
      for (int i = `ROCE_HDR_BYTES; i < `ROCE_RD_RESP_BYTES; i++) begin
        pkt_d[i*8 +: 8] = psn_i[7:0];
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      pkt_q <= '0;
    end else if (cap_i) begin
      pkt_q <= pkt_d;
    end
  end

  assign total_len_o = total_len;
  assign pkt_o       = pkt_q;

endmodule

// File: roce_hdr_pkg.sv
`include "roce_pkt_defs.svh"

package roce_hdr_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  // bth fields
  typedef logic [23:0] qp_num_t;
  typedef logic [23:0] psn_t;

  typedef enum logic [7:0] {
    OP_RD_RESP_ONLY = 8'h10,
    OP_ACK          = 8'h11
  } bth_opcode_e;

  // eth + ipv4 + udp + bth + aeth with byte 0 in the top bits
  typedef logic [`ROCE_HDR_BYTES*8-1:0] hdr_bytes_t;

endpackage

// File: roce_pkt_defs.svh
`ifndef ROCE_PKT_DEFS_SVH
`define ROCE_PKT_DEFS_SVH

// stream width
`define ROCE_DATA_W          512

// packet lengths in bytes
`define ROCE_HDR_BYTES       58
`define ROCE_RD_RESP_BYTES   314
`define ROCE_ACK_BYTES       58

// ipv4 total length per kind
`define ROCE_IP_LEN_RD_RESP  16'h0130
`define ROCE_IP_LEN_ACK      16'h0030

`define ROCE_PKT_PER_PATH    8
`define ROCE_QP_ENTRIES      8

// fixed header fields
`define ROCE_ETHERTYPE       16'h0800
`define ROCE_IP_VER_IHL      8'h45
`define ROCE_IP_TOS          8'hb8
`define ROCE_IP_ID           16'h5555
`define ROCE_IP_FLAGS        16'h4000
`define ROCE_IP_TTL          8'hba
`define ROCE_IP_PROTO_UDP    8'h11
`define ROCE_UDP_SPORT       16'h6851
`define ROCE_UDP_DPORT       16'h12b7
`define ROCE_BTH_PKEY        16'h666f

`endif

// File: roce_resp_gen.f
+incdir+.
roce_hdr_pkg.sv
roce_tx_pkg.sv
qp_addr_table.sv
ipv4_csum.sv
roce_hdr_builder.sv
roce_tx_ctrl.sv
roce_resp_gen_top.sv
roce_resp_gen_checker.sv
tb_roce_resp_gen.sv

// File: roce_resp_gen_checker.sv
`include "roce_pkt_defs.svh"

module roce_resp_gen_checker (
  input logic                      core_clk,
  input logic                      core_aresetn,
  input logic [`ROCE_DATA_W-1:0]   m_tdata_o,
  input logic [`ROCE_DATA_W/8-1:0] m_tkeep_o,
  input logic                      m_tvalid_o,
  input logic                      m_tready_i,
  input logic                      m_tlast_o,
  input logic                      busy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled beat holds until the sink takes it
  stall_stable: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) &&
                                  $stable(m_tkeep_o) && $stable(m_tlast_o))
    else $error("stream beat changed while stalled");

  last_has_valid: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    m_tlast_o |-> m_tvalid_o)
    else $error("tlast high without tvalid");

  valid_in_busy: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    m_tvalid_o |-> busy_o)
    else $error("tvalid high while not busy");

  // first beat only after a request was taken
  no_beat_idle: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $rose(m_tvalid_o) |-> $past(busy_o))
    else $error("beat started from idle");

endmodule

bind roce_resp_gen_top roce_resp_gen_checker u_checker (
  .core_clk     (core_clk),
  .core_aresetn (core_aresetn),
  .m_tdata_o    (m_tdata_o),
  .m_tkeep_o    (m_tkeep_o),
  .m_tvalid_o   (m_tvalid_o),
  .m_tready_i   (m_tready_i),
  .m_tlast_o    (m_tlast_o),
  .busy_o       (busy_o)
);

// File: roce_resp_gen_top.sv
`include "roce_pkt_defs.svh"

module roce_resp_gen_top
  import roce_hdr_pkg::*;
  import roce_tx_pkg::*;
(
  input  logic                                core_clk,
  input  logic                                core_aresetn,
  input  mac_addr_t                           src_mac_i,
  input  ipv4_addr_t                          src_ip_i,
  input  logic                                qp_wr_i,
  input  logic [$clog2(`ROCE_QP_ENTRIES)-1:0] qp_wr_idx_i,
  input  mac_addr_t                           qp_wr_mac_i,
  input  ipv4_addr_t                          qp_wr_ip_i,
  input  logic                                req_i,
  input  req_kind_e                           req_kind_i,
  input  qp_num_t                             req_qp_i,
  input  psn_t                                req_psn_i,
  input  logic                                m_tready_i,
  output logic [`ROCE_DATA_W-1:0]             m_tdata_o,
  output logic [`ROCE_DATA_W/8-1:0]           m_tkeep_o,
  output logic                                m_tvalid_o,
  output logic                                m_tlast_o,
  output logic                                busy_o,
  output logic                                rd_done_o,
  output logic                                wr_done_o
);

  localparam int PKT_W =
    ((`ROCE_RD_RESP_BYTES*8 + `ROCE_DATA_W - 1) / `ROCE_DATA_W) * `ROCE_DATA_W;

  logic             cap;
  req_kind_e        kind;
  qp_num_t          qp;
  psn_t             psn;
  mac_addr_t        dst_mac;
  ipv4_addr_t       dst_ip;
  logic [15:0]      total_len;
  logic [15:0]      csum;
  logic [PKT_W-1:0] pkt;

  qp_addr_table u_qp_addr_table (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .qp_wr_i      (qp_wr_i),
    .qp_wr_idx_i  (qp_wr_idx_i),
    .qp_wr_mac_i  (qp_wr_mac_i),
    .qp_wr_ip_i   (qp_wr_ip_i),
    .rd_idx_i     (qp[$clog2(`ROCE_QP_ENTRIES)-1:0]),
    .rd_mac_o     (dst_mac),
    .rd_ip_o      (dst_ip)
  );

  ipv4_csum u_ipv4_csum (
    .total_len_i (total_len),
    .src_ip_i    (src_ip_i),
    .dst_ip_i    (dst_ip),
    .csum_o      (csum)
  );

  roce_hdr_builder u_roce_hdr_builder (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .cap_i        (cap),
    .kind_i       (kind),
    .qp_i         (qp),
    .psn_i        (psn),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .dst_mac_i    (dst_mac),
    .dst_ip_i     (dst_ip),
    .csum_i       (csum),
    .total_len_o  (total_len),
    .pkt_o        (pkt)
  );

  roce_tx_ctrl #(
    .DATA_W (`ROCE_DATA_W)
  ) u_roce_tx_ctrl (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .req_i        (req_i),
    .req_kind_i   (req_kind_i),
    .req_qp_i     (req_qp_i),
    .req_psn_i    (req_psn_i),
    .pkt_i        (pkt),
    .m_tready_i   (m_tready_i),
    .cap_o        (cap),
    .kind_o       (kind),
    .qp_o         (qp),
    .psn_o        (psn),
    .m_tdata_o    (m_tdata_o),
    .m_tkeep_o    (m_tkeep_o),
    .m_tvalid_o   (m_tvalid_o),
    .m_tlast_o    (m_tlast_o),
    .busy_o       (busy_o),
    .rd_done_o    (rd_done_o),
    .wr_done_o    (wr_done_o)
  );

endmodule

// File: roce_tx_ctrl.sv
`include "roce_pkt_defs.svh"

module roce_tx_ctrl
  import roce_hdr_pkg::*;
  import roce_tx_pkg::*;
#(
  parameter int DATA_W = `ROCE_DATA_W
) (
  input  logic                   core_clk,
  input  logic                   core_aresetn,
  input  logic                   req_i,
  input  req_kind_e              req_kind_i,
  input  qp_num_t                req_qp_i,
  input  psn_t                   req_psn_i,
  input  logic [((`ROCE_RD_RESP_BYTES*8+DATA_W-1)/DATA_W)*DATA_W-1:0] pkt_i,
  input  logic                   m_tready_i,
  output logic                   cap_o,
  output req_kind_e              kind_o,
  output qp_num_t                qp_o,
  output psn_t                   psn_o,
  output logic [DATA_W-1:0]      m_tdata_o,
  output logic [DATA_W/8-1:0]    m_tkeep_o,
  output logic                   m_tvalid_o,
  output logic                   m_tlast_o,
  output logic                   busy_o,
  output logic                   rd_done_o,
  output logic                   wr_done_o
);

  localparam int KEEP_W = DATA_W / 8;
  localparam int BEATS  = (`ROCE_RD_RESP_BYTES*8 + DATA_W - 1) / DATA_W;
  localparam int LEN_W  = $clog2(`ROCE_RD_RESP_BYTES + 1);
  localparam int BEAT_W = $clog2(BEATS + 1);
  localparam int CNT_W  = $clog2(`ROCE_PKT_PER_PATH + 1);

  tx_state_e          state_q;
  logic [LEN_W-1:0]   rem_q;
  logic [BEAT_W-1:0]  beat_q;
  logic [CNT_W-1:0]   rd_cnt_q;
  logic [CNT_W-1:0]   wr_cnt_q;
  logic [KEEP_W-1:0]  keep_d;
  logic               last_d;
  logic               load;
  logic               pkt_end;

  // next beat goes out when the output register is empty or draining
  assign load    = (state_q == TX_STREAM) &&
                   (!m_tvalid_o || (m_tready_i && !m_tlast_o));
  assign pkt_end = m_tvalid_o && m_tready_i && m_tlast_o;
  assign last_d  = rem_q <= LEN_W'(KEEP_W);

  always_comb begin
    for (int i = 0; i < KEEP_W; i++) begin
      keep_d[i] = i < int'(rem_q);
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q    <= TX_IDLE;
      kind_o     <= REQ_RD_RESP;
      qp_o       <= '0;
      psn_o      <= '0;
      rem_q      <= '0;
      beat_q     <= '0;
      m_tkeep_o  <= '0;
      m_tvalid_o <= 1'b0;
      m_tlast_o  <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (req_i) begin
            kind_o  <= req_kind_i;
            qp_o    <= req_qp_i;
            psn_o   <= req_psn_i;
            state_q <= TX_BUILD;
          end
        end
        TX_BUILD: begin
          rem_q   <= (kind_o == REQ_RD_RESP) ? LEN_W'(`ROCE_RD_RESP_BYTES)
                                             : LEN_W'(`ROCE_ACK_BYTES);
          beat_q  <= '0;
          state_q <= TX_STREAM;
        end
        TX_STREAM: begin
          if (pkt_end) begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
            state_q    <= TX_IDLE;
          end else if (load) begin
            m_tkeep_o  <= keep_d;
            m_tvalid_o <= 1'b1;
            m_tlast_o  <= last_d;
            rem_q      <= last_d ? '0 : rem_q - LEN_W'(KEEP_W);
            beat_q     <= beat_q + 1'b1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (load) begin
      m_tdata_o <= pkt_i[beat_q*DATA_W +: DATA_W];
    end
  end

  // per-kind completion counters with sticky done flags
  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      rd_cnt_q  <= '0;
      wr_cnt_q  <= '0;
      rd_done_o <= 1'b0;
      wr_done_o <= 1'b0;
    end else if (pkt_end) begin
      if (kind_o == REQ_RD_RESP && !rd_done_o) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        if (rd_cnt_q == CNT_W'(`ROCE_PKT_PER_PATH - 1)) begin
          rd_done_o <= 1'b1;
        end
      end
      if (kind_o == REQ_ACK && !wr_done_o) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
        if (wr_cnt_q == CNT_W'(`ROCE_PKT_PER_PATH - 1)) begin
          wr_done_o <= 1'b1;
        end
      end
    end
  end

  assign cap_o  = (state_q == TX_BUILD);
  assign busy_o = (state_q != TX_IDLE);

endmodule

// File: roce_tx_pkg.sv
package roce_tx_pkg;

  typedef enum logic {
    REQ_RD_RESP = 1'b0,
    REQ_ACK     = 1'b1
  } req_kind_e;

  // idle, buffer capture, beat walk
  typedef enum logic [1:0] {
    TX_IDLE   = 2'd0,
    TX_BUILD  = 2'd1,
    TX_STREAM = 2'd2
  } tx_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_roce_resp_gen -f roce_resp_gen.f -o Vtb_roce_resp_gen

status=0
./obj_dir/Vtb_roce_resp_gen > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log \
   || ! grep -q "PASS: all tests" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: tb_roce_resp_gen.sv
`include "roce_pkt_defs.svh"

module tb_roce_resp_gen import roce_hdr_pkg::*, roce_tx_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int KEEP_W   = `ROCE_DATA_W / 8;
  localparam int RD_BEATS = (`ROCE_RD_RESP_BYTES + KEEP_W - 1) / KEEP_W;
  localparam int N_RD     = 3 + `ROCE_PKT_PER_PATH;
  localparam int N_ACK    = 1 + `ROCE_PKT_PER_PATH;
  // stall allowance per beat plus request and build gaps per packet
  localparam int LIMIT    = 80 + 8 * (N_RD * RD_BEATS + N_ACK) + 16 * (N_RD + N_ACK);

  logic                     core_clk;
  logic                     core_aresetn;
  mac_addr_t                src_mac;
  ipv4_addr_t               src_ip;
  logic                     qp_wr;
  logic [2:0]               qp_wr_idx;
  mac_addr_t                qp_wr_mac;
  ipv4_addr_t               qp_wr_ip;
  logic                     req;
  req_kind_e                req_kind;
  qp_num_t                  req_qp;
  psn_t                     req_psn;
  logic                     m_tready;
  logic [`ROCE_DATA_W-1:0]  m_tdata;
  logic [KEEP_W-1:0]        m_tkeep;
  logic                     m_tvalid;
  logic                     m_tlast;
  logic                     busy;
  logic                     rd_done;
  logic                     wr_done;

  integer                   seed = 32'hc556;
  logic                     rand_ready;
  int                       cycle_cnt;
  int                       rd_sent;
  int                       ack_sent;
  mac_addr_t                tbl_mac [`ROCE_QP_ENTRIES];
  ipv4_addr_t               tbl_ip [`ROCE_QP_ENTRIES];
  logic [7:0]               exp_bytes [RD_BEATS*KEEP_W];
  int                       exp_len;
  int                       wr_pos;
  logic [`ROCE_DATA_W-1:0]  first_beat;
  logic [`ROCE_DATA_W-1:0]  data_q [$];
  logic [KEEP_W-1:0]        keep_q [$];
  logic                     last_q [$];

  roce_resp_gen_top dut_i (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .src_mac_i    (src_mac),
    .src_ip_i     (src_ip),
    .qp_wr_i      (qp_wr),
    .qp_wr_idx_i  (qp_wr_idx),
    .qp_wr_mac_i  (qp_wr_mac),
    .qp_wr_ip_i   (qp_wr_ip),
    .req_i        (req),
    .req_kind_i   (req_kind),
    .req_qp_i     (req_qp),
    .req_psn_i    (req_psn),
    .m_tready_i   (m_tready),
    .m_tdata_o    (m_tdata),
    .m_tkeep_o    (m_tkeep),
    .m_tvalid_o   (m_tvalid),
    .m_tlast_o    (m_tlast),
    .busy_o       (busy),
    .rd_done_o    (rd_done),
    .wr_done_o    (wr_done)
  );

  initial begin
    core_clk = 1'b0;
    forever #20 core_clk = ~core_clk;
  end

  initial begin
    m_tready = 1'b1;
    forever begin
      @(posedge core_clk);
      m_tready <= rand_ready ? 1'($random(seed)) : 1'b1;
    end
  end

  // beats seen at negedge transfer on the following rising edge
  always @(negedge core_clk) begin
    if (core_aresetn && m_tvalid && m_tready) begin
      data_q.push_back(m_tdata);
      keep_q.push_back(m_tkeep);
      last_q.push_back(m_tlast);
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge core_clk);
      cycle_cnt++;
    end
    $display("timeout: the tests did not complete within %0d cycles", LIMIT);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [`ROCE_DATA_W-1:0] got,
                             input logic [`ROCE_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // big-endian field into the expected byte stream
  task automatic put_field(input int nbytes, input logic [159:0] val);
    for (int k = nbytes - 1; k >= 0; k--) begin
      exp_bytes[wr_pos] = val[k*8 +: 8];
      wr_pos++;
    end
  endtask

  task automatic build_expected(input req_kind_e kind, input qp_num_t qp, input psn_t psn);
    logic [15:0] ip_len;
    logic [7:0]  op;
    logic [31:0] acc;
    begin
      ip_len  = (kind == REQ_RD_RESP) ? `ROCE_IP_LEN_RD_RESP : `ROCE_IP_LEN_ACK;
      op      = (kind == REQ_RD_RESP) ? 8'h10 : 8'h11;
      exp_len = (kind == REQ_RD_RESP) ? `ROCE_RD_RESP_BYTES : `ROCE_ACK_BYTES;
      wr_pos  = 0;
      put_field(14, {tbl_mac[qp[2:0]], src_mac, `ROCE_ETHERTYPE});
      put_field(20, {`ROCE_IP_VER_IHL, `ROCE_IP_TOS, ip_len, `ROCE_IP_ID, `ROCE_IP_FLAGS,
                     `ROCE_IP_TTL, `ROCE_IP_PROTO_UDP, 16'h0000, src_ip, tbl_ip[qp[2:0]]});
      put_field(8, {`ROCE_UDP_SPORT, `ROCE_UDP_DPORT, 16'(ip_len - 16'd20), 16'h0000});
      put_field(12, {op, 8'h00, `ROCE_BTH_PKEY, 8'h00, qp, 8'h00, psn});
      put_field(4, 32'h0000_0000);
      for (int i = wr_pos; i < RD_BEATS * KEEP_W; i++) begin
        exp_bytes[i] = (i < exp_len) ? psn[7:0] : 8'h00;
      end
      // one's-complement sum over ipv4 header bytes 14 to 33
      acc = '0;
      for (int i = 14; i < 34; i += 2) begin
        acc = acc + 32'({exp_bytes[i], exp_bytes[i + 1]});
      end
      while (acc[31:16] != 16'h0000) begin
        acc = 32'(acc[31:16]) + 32'(acc[15:0]);
      end
      exp_bytes[24] = ~acc[15:8];
      exp_bytes[25] = ~acc[7:0];
    end
  endtask

  task automatic write_entry(input logic [2:0] idx, input mac_addr_t mac, input ipv4_addr_t ip);
    @(posedge core_clk);
    qp_wr     <= 1'b1;
    qp_wr_idx <= idx;
    qp_wr_mac <= mac;
    qp_wr_ip  <= ip;
    @(posedge core_clk);
    qp_wr        <= 1'b0;
    tbl_mac[idx] = mac;
    tbl_ip[idx]  = ip;
  endtask

  task automatic issue_request(input req_kind_e kind, input qp_num_t qp, input psn_t psn);
    @(posedge core_clk);
    req      <= 1'b1;
    req_kind <= kind;
    req_qp   <= qp;
    req_psn  <= psn;
    @(posedge core_clk);
    req <= 1'b0;
  endtask

  task automatic collect_packet(input req_kind_e kind);
    int                      beats;
    logic [`ROCE_DATA_W-1:0] data;
    logic [`ROCE_DATA_W-1:0] mask;
    logic [`ROCE_DATA_W-1:0] got;
    logic [KEEP_W-1:0]       keep;
    begin
      beats = (exp_len + KEEP_W - 1) / KEEP_W;
      while (data_q.size() < beats) begin
        @(posedge core_clk);
      end
      for (int b = 0; b < beats; b++) begin
        for (int j = 0; j < KEEP_W; j++) begin
          data[j*8 +: 8] = exp_bytes[b*KEEP_W + j];
          keep[j]        = (b*KEEP_W + j) < exp_len;
          mask[j*8 +: 8] = {8{keep[j]}};
        end
        got = data_q.pop_front();
        if (b == 0) begin
          first_beat = got;
        end
        check_value("m_tkeep_o", keep_q.pop_front(), keep);
        check_value("m_tlast_o", last_q.pop_front(), b == beats - 1);
        check_value("m_tdata_o", got & mask, data & mask);
      end
      // one negedge past the edge that took the last beat
      @(negedge core_clk);
      if (kind == REQ_RD_RESP) begin
        rd_sent++;
      end else begin
        ack_sent++;
      end
      check_value("busy_o", busy, 1'b0);
      check_value("rd_done_o", rd_done, rd_sent >= `ROCE_PKT_PER_PATH);
      check_value("wr_done_o", wr_done, ack_sent >= `ROCE_PKT_PER_PATH);
    end
  endtask

  task automatic run_packet(input req_kind_e kind, input qp_num_t qp, input psn_t psn);
    while (busy) begin
      @(negedge core_clk);
    end
    build_expected(kind, qp, psn);
    issue_request(kind, qp, psn);
    collect_packet(kind);
  endtask

  task automatic test_rd_resp();
    for (int i = 2; i < `ROCE_QP_ENTRIES; i++) begin
      write_entry(3'(i), 48'h021c_7ea0_0000 + 48'(i) * 48'h0101,
                  32'hc0a8_0a00 + 32'(i) * 32'h0103);
    end
    // upper qp bits go into the bth but not into the table index
    run_packet(REQ_RD_RESP, 24'h0a_0003, 24'h00_1234);
  endtask

  task automatic test_ack();
    run_packet(REQ_ACK, 24'h00_0006, 24'h5a_c3e1);
    check_value("bth opcode", first_beat[42*8 +: 8], 8'h11);
    check_value("ip total length", {first_beat[16*8 +: 8], first_beat[17*8 +: 8]}, 16'h0030);
    check_value("udp length", {first_beat[38*8 +: 8], first_beat[39*8 +: 8]}, 16'h001c);
    check_value("bth psn", {first_beat[51*8 +: 8], first_beat[52*8 +: 8],
                            first_beat[53*8 +: 8]}, 24'h5a_c3e1);
  endtask

  task automatic test_backpressure();
    rand_ready = 1'b1;
    run_packet(REQ_RD_RESP, 24'h00_0005, 24'h00_77a9);
    rand_ready = 1'b0;
  endtask

  task automatic test_busy_drop();
    build_expected(REQ_RD_RESP, 24'h00_0004, 24'h00_0abc);
    issue_request(REQ_RD_RESP, 24'h00_0004, 24'h00_0abc);
    @(negedge core_clk);
    check_value("busy_o", busy, 1'b1);
    issue_request(REQ_ACK, 24'h00_0007, 24'h00_0def);
    collect_packet(REQ_RD_RESP);
    repeat (12) @(negedge core_clk);
    check_value("beats after drop", 32'(data_q.size()), 32'd0);
    check_value("busy_o", busy, 1'b0);
  endtask

  task automatic test_done_flags();
    for (int i = 0; i < `ROCE_PKT_PER_PATH; i++) begin
      run_packet(REQ_RD_RESP, 24'(i), 24'h00_0100 + 24'(i));
      run_packet(REQ_ACK, 24'(i), 24'h00_0200 + 24'(i));
    end
    check_value("rd_done_o", rd_done, 1'b1);
    check_value("wr_done_o", wr_done, 1'b1);
  endtask

  initial begin
    core_aresetn = 1'b0;
    src_mac      = 48'h0a1b_2c3d_4e5f;
    src_ip       = 32'hc0a8_0101;
    qp_wr        = 1'b0;
    qp_wr_idx    = '0;
    qp_wr_mac    = '0;
    qp_wr_ip     = '0;
    req          = 1'b0;
    req_kind     = REQ_RD_RESP;
    req_qp       = '0;
    req_psn      = '0;
    rand_ready   = 1'b0;
    rd_sent      = 0;
    ack_sent     = 0;
    for (int i = 0; i < `ROCE_QP_ENTRIES; i++) begin
      tbl_mac[i] = '0;
      tbl_ip[i]  = '0;
    end
    repeat (16) @(posedge core_clk);
    core_aresetn <= 1'b1;
    @(negedge core_clk);
    check_value("m_tvalid_o", m_tvalid, 1'b0);
    check_value("m_tlast_o", m_tlast, 1'b0);
    check_value("busy_o", busy, 1'b0);
    check_value("rd_done_o", rd_done, 1'b0);
    check_value("wr_done_o", wr_done, 1'b0);
    test_rd_resp();
    test_ack();
    test_backpressure();
    test_busy_drop();
    test_done_flags();
    $display("PASS: all tests");
    $finish;
  end

endmodule
